//--- Bender.yml
package:
  name: mips_core

export_include_dirs:
  - include

sources:
  - logic/mipsPkg.sv
  - logic/ctrlIf.sv
  - logic/fetchStage.sv
  - logic/decodeStage.sv
  - logic/regFile.sv
  - logic/execWbStage.sv
  - logic/mipsCore.sv
  - target: test
    files:
      - verification/clockGen.sv
      - verification/mipsCoreTb.sv

//--- build.f
+incdir+include
logic/mipsPkg.sv
logic/ctrlIf.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/regFile.sv
logic/execWbStage.sv
logic/mipsCore.sv
verification/clockGen.sv
verification/mipsCoreTb.sv

//--- include/mips_defs.svh
//====================================================================
// MIPS subset encodings
// opcodes, funct codes, ALU operation codes and fixed sizes shared by
// the single cycle core and its testbench
//====================================================================
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// main opcodes, instr[31:26]
`define OPC_RTYPE 6'b000000
`define OPC_LW    6'b100011
`define OPC_SW    6'b101011
`define OPC_BEQ   6'b000100
`define OPC_J     6'b000010
`define OPC_JAL   6'b000011

// funct field of R-type, instr[5:0]
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_OR  6'b100101
`define FN_SLT 6'b101010
`define FN_JR  6'b001000

// ALU operation codes
`define ALU_AND 4'b0000
`define ALU_OR  4'b0001
`define ALU_ADD 4'b0010
`define ALU_SUB 4'b0110
`define ALU_SLT 4'b0111

// ALU operation class from decode
`define ALUOP_MEM   2'b00  // address add for lw/sw
`define ALUOP_BEQ   2'b01  // compare by subtraction
`define ALUOP_FUNCT 2'b10  // funct field decides

`define LINK_REG 5'd31  // jal return address register
`define DMEM_AW  7      // data SRAM word address width

`endif

//--- logic/ctrlIf.sv
//====================================================================
// Control bundle
// decoded control of the current instruction, decode to execute/wb
// and to next pc selection
//====================================================================
`timescale 1ns/10ps

interface ctrlIf;
  logic       aluSrc;    // immediate as second ALU operand
  logic [1:0] aluOp;     // ALU operation class
  logic       memRead;   // lw
  logic       memWrite;  // sw
  logic       memToReg;  // writeback from SRAM
  logic       regWrite;
  logic       branch;    // beq
  logic       jump;      // j and jal
  logic       jumpReg;   // jr
  logic       link;      // jal writes pc+4

  modport dec (output aluSrc, aluOp, memRead, memWrite, memToReg,
               regWrite, branch, jump, jumpReg, link);
  modport exe (input aluSrc, aluOp, memRead, memWrite, memToReg,
               branch, link);
  modport fetch (input jump, jumpReg);
endinterface

//--- logic/decodeStage.sv
//====================================================================
// Decode stage
// main control decoder, opcode and funct to the control bundle
// plus source and destination register numbers
//====================================================================
`timescale 1ns/10ps
`include "mips_defs.svh"

module decodeStage
  import mipsPkg::*;
(
  input  instrWord   ir,
  ctrlIf.dec         ctl,
  output logic [4:0] rsAddr,
  output logic [4:0] rtAddr,
  output logic [4:0] rdAddr  // write destination
);

  assign rsAddr = ir.rFmt.rs;
  assign rtAddr = ir.rFmt.rt;

  // ==================================================================
  // control decode
  // ==================================================================
  always_comb begin
    // defaults, retire as no-op
    ctl.aluSrc   = 1'b0;
    ctl.aluOp    = `ALUOP_MEM;
    ctl.memRead  = 1'b0;
    ctl.memWrite = 1'b0;
    ctl.memToReg = 1'b0;
    ctl.regWrite = 1'b0;
    ctl.branch   = 1'b0;
    ctl.jump     = 1'b0;
    ctl.jumpReg  = 1'b0;
    ctl.link     = 1'b0;
    rdAddr       = 5'd0;

    case (ir.rFmt.opcode)
      `OPC_RTYPE: begin
        ctl.aluOp = `ALUOP_FUNCT;
        case (ir.rFmt.funct)
          `FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT: begin
            ctl.regWrite = 1'b1;
            rdAddr       = ir.rFmt.rd;
          end
          `FN_JR: ctl.jumpReg = 1'b1;  // no register write
          default: ;                    // unknown funct stays no-op
        endcase
      end
      `OPC_LW: begin
        ctl.aluSrc   = 1'b1;  // base + offset
        ctl.memRead  = 1'b1;
        ctl.memToReg = 1'b1;
        ctl.regWrite = 1'b1;
        rdAddr       = ir.iFmt.rt;
      end
      `OPC_SW: begin
        ctl.aluSrc   = 1'b1;
        ctl.memWrite = 1'b1;
      end
      `OPC_BEQ: begin
        ctl.aluOp  = `ALUOP_BEQ;  // rs - rt
        ctl.branch = 1'b1;
      end
      `OPC_J: ctl.jump = 1'b1;
      `OPC_JAL: begin
        ctl.jump     = 1'b1;
        ctl.link     = 1'b1;
        ctl.regWrite = 1'b1;
        rdAddr       = `LINK_REG;  // return address into r31
      end
      default: ;  // undefined opcode, everything off
    endcase
  end

endmodule

//--- logic/execWbStage.sv
//====================================================================
// Execute and writeback stage
// ALU control and ALU, beq decision and target, data SRAM port
// with active low enables, writeback data select
//====================================================================
`timescale 1ns/10ps
`include "mips_defs.svh"

module execWbStage
  import mipsPkg::*;
(
  ctrlIf.exe                   ctl,
  input  instrWord             ir,
  input  logic [31:0]          rsData,
  input  logic [31:0]          rtData,
  input  logic [31:0]          pcPlus4,
  input  logic [31:0]          memRdData,  // SRAM read, same cycle
  output logic                 takeBranch,
  output logic [31:0]          branchTarget,
  output logic                 cen,
  output logic                 wen,
  output logic                 oen,
  output logic [`DMEM_AW-1:0]  memAddr,
  output logic [31:0]          memWrData,
  output logic [31:0]          wbData
);

  logic [3:0]  aluCode;
  logic [31:0] immExt;
  logic [31:0] aluB;
  logic [31:0] aluRes;
  logic        aluZero;

  assign immExt = {{16{ir.iFmt.imm[15]}}, ir.iFmt.imm};  // sign extend
  assign aluB   = ctl.aluSrc ? immExt : rtData;

  // ==================================================================
  // ALU control
  // ==================================================================
  always_comb begin
    case (ctl.aluOp)
      `ALUOP_MEM: aluCode = `ALU_ADD;  // lw/sw address
      `ALUOP_BEQ: aluCode = `ALU_SUB;
      default: begin
        case (ir.rFmt.funct)
          `FN_ADD: aluCode = `ALU_ADD;
          `FN_SUB: aluCode = `ALU_SUB;
          `FN_AND: aluCode = `ALU_AND;
          `FN_OR:  aluCode = `ALU_OR;
          `FN_SLT: aluCode = `ALU_SLT;
          default: aluCode = `ALU_ADD;  // jr and unknown, result unused
        endcase
      end
    endcase
  end

  // ALU
  always_comb begin
    case (aluCode)
      `ALU_AND: aluRes = rsData & aluB;
      `ALU_OR:  aluRes = rsData | aluB;
      `ALU_SUB: aluRes = rsData - aluB;
      `ALU_SLT: aluRes = {31'd0, ($signed(rsData) < $signed(aluB))};  // signed
      default:  aluRes = rsData + aluB;
    endcase
  end

  assign aluZero = (aluRes == 32'd0);

  // beq decision and target
  assign takeBranch   = ctl.branch & aluZero;
  assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};

  // ==================================================================
  // data SRAM port, enables active low
  // ==================================================================
  assign cen       = ~(ctl.memRead | ctl.memWrite);
  assign wen       = ~ctl.memWrite;
  assign oen       = ~ctl.memRead;
  assign memAddr   = aluRes[`DMEM_AW+1:2];  // byte address to word address
  assign memWrData = rtData;

  // writeback select, link wins
  assign wbData = ctl.link     ? pcPlus4   :
                  ctl.memToReg ? memRdData :
                                 aluRes;

endmodule

//--- logic/fetchStage.sv
//====================================================================
// Fetch stage
// program counter register and next pc selection
// priority jr, then j/jal, then taken beq, then pc+4
//====================================================================
`timescale 1ns/10ps

module fetchStage (
  input  logic        clk,
  input  logic        rst,
  ctrlIf.fetch        ctl,
  input  logic        takeBranch,    // beq with equal operands
  input  logic [31:0] branchTarget,  // pc+4 + offset
  input  logic [25:0] jumpTarget,    // j/jal word target
  input  logic [31:0] regTarget,     // rs value for jr
  output logic [31:0] pc,
  output logic [31:0] pcPlus4
);

  logic [31:0] nextPc;
  logic [31:0] jumpAddr;

  assign pcPlus4  = pc + 32'd4;
  // pseudo-direct address, region from pc+4
  assign jumpAddr = {pcPlus4[31:28], jumpTarget, 2'b00};

  // ==================================================================
  // next pc
  // ==================================================================
  always_comb begin
    if (ctl.jumpReg) begin
      nextPc = regTarget;     // jr
    end else if (ctl.jump) begin
      nextPc = jumpAddr;      // j, jal
    end else if (takeBranch) begin
      nextPc = branchTarget;  // beq taken
    end else begin
      nextPc = pcPlus4;       // sequential, also no-op
    end
  end

  // pc register, moves every edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= 32'd0;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

//--- logic/mipsCore.sv
//====================================================================
// Single cycle MIPS core
// fetch, decode, register file and execute/writeback in one cycle
// instruction port read same cycle, data SRAM with active low enables
//====================================================================
`timescale 1ns/10ps
`include "mips_defs.svh"

module mipsCore
  import mipsPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [31:0]         ir,           // instruction at irAddr
  output logic [31:0]         irAddr,
  input  logic [31:0]         memRdData,
  output logic                cen,
  output logic                wen,
  output logic                oen,
  output logic [`DMEM_AW-1:0] memAddr,
  output logic [31:0]         memWrData,
  output logic                rfWriteEn,    // register write observation
  output logic [4:0]          rfWriteAddr,
  output logic [31:0]         rfWriteData
);

  instrWord    irWord;
  logic [31:0] pc;
  logic [31:0] pcPlus4;
  logic [4:0]  rsAddr;
  logic [4:0]  rtAddr;
  logic [31:0] rsData;
  logic [31:0] rtData;
  logic        takeBranch;
  logic [31:0] branchTarget;
  logic        exCen;  // enables before qualification
  logic        exWen;
  logic        exOen;
  logic        coreValid;  // low until first edge after reset

  ctrlIf ctlBus ();

  assign irWord = ir;
  assign irAddr = pc;

  // ==================================================================
  // post reset valid flag
  // ==================================================================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      coreValid <= 1'b0;
    end else begin
      coreValid <= 1'b1;
    end
  end

  assign rfWriteEn = ctlBus.regWrite & coreValid;
  assign cen       = exCen | ~coreValid;  // SRAM idle until valid
  assign wen       = exWen | ~coreValid;
  assign oen       = exOen | ~coreValid;

  fetchStage fetch0 (
    .clk(clk), .rst(rst), .ctl(ctlBus.fetch), .takeBranch(takeBranch),
    .branchTarget(branchTarget), .jumpTarget(irWord.jFmt.target),
    .regTarget(rsData), .pc(pc), .pcPlus4(pcPlus4)
  );

  decodeStage decode0 (
    .ir(irWord), .ctl(ctlBus.dec), .rsAddr(rsAddr), .rtAddr(rtAddr),
    .rdAddr(rfWriteAddr)
  );

  regFile regs0 (
    .clk(clk), .rst(rst), .rsAddr(rsAddr), .rtAddr(rtAddr),
    .wrAddr(rfWriteAddr), .wrEn(rfWriteEn), .wrData(rfWriteData),
    .rsData(rsData), .rtData(rtData)
  );

  execWbStage exec0 (
    .ctl(ctlBus.exe), .ir(irWord), .rsData(rsData), .rtData(rtData),
    .pcPlus4(pcPlus4), .memRdData(memRdData), .takeBranch(takeBranch),
    .branchTarget(branchTarget), .cen(exCen), .wen(exWen), .oen(exOen),
    .memAddr(memAddr), .memWrData(memWrData), .wbData(rfWriteData)
  );

endmodule

//--- logic/mipsPkg.sv
//====================================================================
// MIPS core types
// instruction word as a packed union over the R, I and J formats
//====================================================================
package mipsPkg;

  // register format, arithmetic and jr
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;  // not used by this subset
    logic [5:0] funct;
  } rFmtT;

  // immediate format, lw / sw / beq
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iFmtT;

  // jump format, j / jal
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } jFmtT;

  // one 32-bit word, three views
  // opcode sits in the same bits in every view
  typedef union packed {
    rFmtT rFmt;
    iFmtT iFmt;
    jFmtT jFmt;
  } instrWord;

endpackage

//--- logic/regFile.sv
//====================================================================
// Register file
// registers 1..31 with two combinational read ports and one write
// port at the rising edge; register 0 is constant zero
//====================================================================
`timescale 1ns/10ps

module regFile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rsAddr,
  input  logic [4:0]  rtAddr,
  input  logic [4:0]  wrAddr,
  input  logic        wrEn,
  input  logic [31:0] wrData,
  output logic [31:0] rsData,
  output logic [31:0] rtData
);

  logic [31:0] regs [1:31];  // no storage for r0

  // ==================================================================
  // write port
  // ==================================================================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wrEn && (wrAddr != 5'd0)) begin
      regs[wrAddr] <= wrData;  // writes to r0 dropped
    end
  end

  // read ports, r0 forced to zero
  always_comb begin
    rsData = 32'd0;
    rtData = 32'd0;
    if (rsAddr != 5'd0) begin
      rsData = regs[rsAddr];
    end
    if (rtAddr != 5'd0) begin
      rtData = regs[rtAddr];
    end
  end

endmodule

//--- verification/clockGen.sv
//====================================================================
// Testbench clock
// free running clock with an 8 ns period
//====================================================================
`timescale 1ns/10ps

module clockGen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;  // half period

endmodule

//--- verification/mipsCoreTb.sv
//====================================================================
// MIPS core testbench
// instruction ROM and data SRAM models around the core with the
// program and expected register write and store traces from a file
//====================================================================
`timescale 1ns/10ps
`include "mips_defs.svh"

module mipsCoreTb;

  // words on the instruction port while reset holds the core
  localparam logic [31:0] lwProbe = {`OPC_LW, 5'd0, 5'd1, 16'd0};  // lw r1,0(r0)
  localparam logic [31:0] swProbe = {`OPC_SW, 5'd0, 5'd1, 16'd0};  // sw r1,0(r0)

  logic                clk;
  logic                rst;
  logic [31:0]         ir;
  logic [31:0]         irAddr;
  logic [31:0]         memRdData;
  logic                cen;
  logic                wen;
  logic                oen;
  logic [`DMEM_AW-1:0] memAddr;
  logic [31:0]         memWrData;
  logic                rfWriteEn;
  logic [4:0]          rfWriteAddr;
  logic [31:0]         rfWriteData;

  logic [31:0] rom [0:63];                 // program store of 64 words
  logic [31:0] sram [0:(1<<`DMEM_AW)-1];   // 128 word data SRAM
  logic [31:0] wrAddrQ[$];                 // expected register writes
  logic [31:0] wrDataQ[$];
  logic [31:0] stAddrQ[$];                 // expected stores
  logic [31:0] stDataQ[$];
  logic [31:0] haltPc;                     // pc of the self-jump
  logic [31:0] resetIr;                    // instruction port during reset
  int          wrCnt;
  int          stCnt;
  int          cycles;
  logic        halted;

  clockGen clkGen0 (.clk(clk));

  mipsCore dut0 (
    .clk(clk), .rst(rst), .ir(ir), .irAddr(irAddr), .memRdData(memRdData),
    .cen(cen), .wen(wen), .oen(oen), .memAddr(memAddr), .memWrData(memWrData),
    .rfWriteEn(rfWriteEn), .rfWriteAddr(rfWriteAddr), .rfWriteData(rfWriteData)
  );

  // ==================================================================
  // memory models
  // ==================================================================
  assign ir        = rst ? resetIr : rom[irAddr[7:2]];          // same cycle fetch
  assign memRdData = (!cen && !oen) ? sram[memAddr] : 32'd0;    // async read

  always @(posedge clk) begin
    if (!cen && !wen) begin
      sram[memAddr] <= memWrData;  // store lands at the edge
    end
  end

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      stopRun($sformatf("ERROR %s expected %h actual %h", name, exp, act));
    end
  endtask

  // idle core with pc at zero and SRAM deselected
  task automatic checkIdle(input string when);
    checkEq({when, " irAddr"}, 32'd0, irAddr);
    checkEq({when, " cen"}, 32'd1, cen);
    checkEq({when, " wen"}, 32'd1, wen);
    checkEq({when, " oen"}, 32'd1, oen);
    checkEq({when, " rfWriteEn"}, 32'd0, rfWriteEn);
  endtask

  // compare this cycle's register write and store with the traces
  task automatic checkCycle();
    logic [31:0] expAddr;
    logic [31:0] expData;
    if (rfWriteEn) begin
      if (wrAddrQ.size() == 0) begin
        stopRun("register write seen after the expected trace ended");
      end else begin
        expAddr = wrAddrQ.pop_front();
        expData = wrDataQ.pop_front();
        checkEq($sformatf("reg write %0d addr", wrCnt), expAddr, rfWriteAddr);
        checkEq($sformatf("reg write %0d data", wrCnt), expData, rfWriteData);
        wrCnt++;
      end
    end
    if (!cen && !wen) begin
      if (stAddrQ.size() == 0) begin
        stopRun("store seen after the expected store log ended");
      end else begin
        expAddr = stAddrQ.pop_front();
        expData = stDataQ.pop_front();
        checkEq($sformatf("store %0d addr", stCnt), expAddr, memAddr);
        checkEq($sformatf("store %0d data", stCnt), expData, memWrData);
        stCnt++;
      end
    end
  endtask

  // ==================================================================
  // stimulus file with one tag per entry and # comments
  // ==================================================================
  task automatic loadStim();
    int          fd;
    int          code;
    int          pIdx;
    logic [7:0]  tag;
    logic [31:0] a;
    logic [31:0] d;
    string       rest;
    pIdx = 0;
    fd = $fopen("verification/mips_stim.txt", "r");
    if (fd == 0) begin
      stopRun("could not open the stimulus file verification/mips_stim.txt");
    end else begin
      while ($fscanf(fd, " %c", tag) == 1) begin
        case (tag)
          "#": code = $fgets(rest, fd);
          "P": begin
            code = $fscanf(fd, "%h", d);
            rom[pIdx] = d;  // program words in address order
            pIdx++;
            if (code != 1) begin
              stopRun("a program word in the stimulus file could not be read");
            end
          end
          "D": begin
            code = $fscanf(fd, "%h %h", a, d);
            sram[a] = d;
            if (code != 2) begin
              stopRun("a data memory entry in the stimulus file could not be read");
            end
          end
          "W": begin
            code = $fscanf(fd, "%h %h", a, d);
            wrAddrQ.push_back(a);
            wrDataQ.push_back(d);
            if (code != 2) begin
              stopRun("a register write entry in the stimulus file could not be read");
            end
          end
          "S": begin
            code = $fscanf(fd, "%h %h", a, d);
            stAddrQ.push_back(a);
            stDataQ.push_back(d);
            if (code != 2) begin
              stopRun("a store entry in the stimulus file could not be read");
            end
          end
          "H": begin
            code = $fscanf(fd, "%h", haltPc);
            if (code != 1) begin
              stopRun("the halt address in the stimulus file could not be read");
            end
          end
          default: stopRun($sformatf("unknown tag %c in the stimulus file", tag));
        endcase
      end
      $fclose(fd);
    end
  endtask

  // ==================================================================
  // main sequence
  // ==================================================================
  initial begin
    rst     = 1'b1;
    resetIr = lwProbe;
    haltPc  = 32'd0;
    wrCnt   = 0;
    stCnt   = 0;
    for (int i = 0; i < 64; i++) begin
      rom[i] = 32'hfc00_0000 | i;  // undefined opcode tagged with address
    end
    for (int i = 0; i < (1 << `DMEM_AW); i++) begin
      sram[i] = 32'h5a5a_0000 | i;
    end
    loadStim();

    // load and store probes alternate during reset
    for (int n = 0; n < 16; n++) begin
      @(posedge clk);
      checkIdle("reset");
      #1 resetIr = (n % 2 == 0) ? swProbe : lwProbe;
    end
    rst = 1'b0;  // released 1 ns after the 16th edge

    cycles = 0;
    halted = 1'b0;
    while (!halted && cycles < 2000) begin
      @(negedge clk);  // mid cycle where outputs have settled
      if (cycles == 0) begin
        checkIdle("first edge after reset");
      end
      checkCycle();
      halted = (irAddr == haltPc);
      cycles++;
    end

    if (!halted) begin
      stopRun("the program never reached its halt loop within 2000 cycles");
    end else if (wrAddrQ.size() != 0 || stAddrQ.size() != 0) begin
      stopRun("halted with expected register writes or stores still outstanding");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

//--- verification/mips_stim.txt
# P word: program word from address 0 up; D addr data: initial SRAM word; H pc: halt address
# W reg data: expected register write in order; S addr data: expected store (word address)
D 00 00000005  D 01 fffffffd  D 02 0000000c
P 00000000  P 8c010000   # 00 nop, lost to reset   04 lw r1,0(r0)
P 8c020004  P 8c030008   # 08 lw r2,4(r0)          0c lw r3,8(r0)
P 00232020  P 00232822   # 10 add r4,r1,r3         14 sub r5,r1,r3
P 00233024  P 00233825   # 18 and r6,r1,r3         1c or r7,r1,r3
P 0041402a  P 00210020   # 20 slt r8,r2,r1         24 add r0,r1,r1
P 00015020  P ac04000c   # 28 add r10,r0,r1        2c sw r4,12(r0)
P 8c0b000c  P 10230005   # 30 lw r11,12(r0)        34 beq r1,r3 not taken
P 102a0001  P 00216820   # 38 beq r1,r10 taken     3c add r13 skipped
P 0c000014  P fc000000   # 40 jal 50               44 undefined opcode
P 00237820  P 08000013   # 48 add r15,r1,r3        4c j 4c, halt
P 00637020  P 08000017   # 50 add r14,r3,r3        54 j 5c
P 00216820  P 03e00008   # 58 add r13 skipped      5c jr r31
H 0000004c
W 01 00000005  W 02 fffffffd  W 03 0000000c
W 04 00000011  W 05 fffffff9  W 06 00000004
W 07 0000000d  W 08 00000001  W 00 0000000a
W 0a 00000005  W 0b 00000011  W 1f 00000044
W 0e 00000018  W 0f 00000011
S 03 00000011
